// ==== all.f ====
+incdir+testbench
rtl/trs_host_pkg.sv
rtl/download_router.sv
rtl/alt_boot_rom.sv
rtl/reset_control.sv
rtl/debug_line_select.sv
rtl/audio_mixer.sv
rtl/trs_host_top.sv
testbench/tb_trs_host.sv

// ==== rtl/alt_boot_rom.sv ====
// Alternate boot ROM
// Dual-port byte memory, loaded by the host and read back by the machine

`timescale 1ns/1ps

module alt_boot_rom import trs_host_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      rom_wr,
	input  logic [alt_rom_addr_w-1:0] rom_addr,
	input  byte_t                     rom_data,
	input  logic [alt_rom_addr_w-1:0] rom_read_addr,
	output byte_t                     rom_read_data
);

	byte_t mem [0:(2**alt_rom_addr_w)-1];

	// Port A, host writes only
	always_ff @(posedge clk_sys) begin
		if (rom_wr) begin
			mem[rom_addr] <= rom_data;
		end
	end

	// Port B, registered machine read
	always_ff @(posedge clk_sys) begin
		rom_read_data <= mem[rom_read_addr];
	end

endmodule

// ==== rtl/audio_mixer.sv ====
// Audio mixer
// Adds scaled machine sound to the external sample and clamps to 16 bits

`timescale 1ns/1ps

module audio_mixer import trs_host_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   sys_reset,
	input  logic [sys_audio_w-1:0] sys_audio,
	input  audio_t                 ext_audio,
	input  logic                   ext_audio_mute,
	output audio_t                 audio_out
);

	logic [audio_w:0] sys_term;
	logic [audio_w:0] ext_term;
	logic [audio_w:0] sum;

	// Machine sound is unsigned, scaled up into the signed range
	assign sys_term = {{(audio_w + 1 - sys_audio_w){1'b0}}, sys_audio} << sys_audio_shift;
	assign ext_term = ext_audio_mute ? '0 : {ext_audio[audio_w-1], ext_audio};

	always_ff @(posedge clk_sys or posedge sys_reset) begin
		if (sys_reset) begin
			sum       <= '0;
			audio_out <= '0;
		end else begin
			// Stage one
			sum <= sys_term + ext_term;

			// Stage two, saturate when the two top bits disagree
			if (sum[audio_w] != sum[audio_w-1]) begin
				audio_out <= {sum[audio_w], {(audio_w - 1){~sum[audio_w]}}};
			end else begin
				audio_out <= sum[audio_w-1:0];
			end
		end
	end

endmodule

// ==== rtl/debug_line_select.sv ====
// Debug status line selector
// Toggled by the host request, forced on when the execute address moves

`timescale 1ns/1ps

module debug_line_select import trs_host_pkg::*; (
	input  logic       clk_sys,
	input  logic       sys_reset,
	input  logic       debug_request,
	input  host_addr_t execute_addr,
	output logic       debug_select_line
);

	logic       request_q;
	host_addr_t execute_q;

	// Address history tracks the input even in reset, so no false set afterwards
	always_ff @(posedge clk_sys) begin
		execute_q <= execute_addr;
	end

	always_ff @(posedge clk_sys or posedge sys_reset) begin
		if (sys_reset) begin
			request_q         <= 1'b0;
			debug_select_line <= 1'b0;
		end else begin
			request_q <= debug_request;
			if (execute_addr != execute_q) begin
				// New execute address, always show it
				debug_select_line <= 1'b1;
			end else if (request_q && !debug_request) begin
				debug_select_line <= !debug_select_line;
			end
		end
	end

endmodule

// ==== rtl/download_router.sv ====
// Host download router
// Sends each download strobe to shared memory or to the alternate boot ROM

`timescale 1ns/1ps

module download_router import trs_host_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      sys_reset,
	input  logic                      dl_active,
	input  logic                      dl_wr,
	input  logic [index_w-1:0]        dl_index,
	input  host_addr_t                dl_addr,
	input  byte_t                     dl_data,
	output logic                      rom_download,
	output logic                      cassette_download,
	output logic                      mem_wr,
	output mem_addr_t                 mem_addr,
	output byte_t                     mem_data,
	output logic                      rom_wr,
	output logic [alt_rom_addr_w-1:0] rom_addr,
	output byte_t                     rom_data
);

	logic wr_strobe;
	logic to_mem;
	logic to_rom;
	logic region;

	assign wr_strobe = dl_active & dl_wr;

	// Status flags for the machine and the reset block
	assign rom_download      = dl_active && (dl_index == idx_system_rom);
	assign cassette_download = dl_active && (dl_index == idx_cassette);

	// File index decode
	always_comb begin
		to_mem = 1'b0;
		to_rom = 1'b0;
		region = 1'b0;
		case (dl_index)
			idx_system_rom: to_mem = 1'b1;
			idx_cassette: begin
				to_mem = 1'b1;
				region = 1'b1;
			end
			idx_alt_rom: to_rom = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or posedge sys_reset) begin
		if (sys_reset) begin
			mem_wr <= 1'b0;
			rom_wr <= 1'b0;
		end else begin
			mem_wr <= wr_strobe & to_mem;
			rom_wr <= wr_strobe & to_rom;
		end
	end

	// Address and data held until the next strobe
	always_ff @(posedge clk_sys) begin
		if (wr_strobe) begin
			mem_addr <= {region, dl_addr};
			mem_data <= dl_data;
			rom_addr <= dl_addr[alt_rom_addr_w-1:0];
			rom_data <= dl_data;
		end
	end

endmodule

// ==== rtl/reset_control.sv ====
// Reset generation
// Merges the reset sources and stretches a pulse on each boot ROM mode switch

`timescale 1ns/1ps

module reset_control import trs_host_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	input  logic reset_request,
	input  logic button_reset,
	input  logic rom_download,
	input  logic alt_rom_mode,
	output logic sys_reset,
	output logic mapper_reset
);

	typedef logic [$clog2(mode_reset_cycles + 1)-1:0] mode_count_t;

	logic        mode_q;
	mode_count_t mode_count;
	logic        mode_pulse;

	// Previous mode level, follows the input through reset too
	always_ff @(posedge clk_sys) begin
		mode_q <= alt_rom_mode;
	end

	// Pulse counter, only the external reset clears it
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			mode_count <= '0;
		end else if (mode_q != alt_rom_mode) begin
			mode_count <= mode_count_t'(mode_reset_cycles);
		end else if (mode_count != '0) begin
			mode_count <= mode_count - 1'b1;
		end
	end

	assign mode_pulse = (mode_count != '0);

	// ====================
	// Reset outputs
	// ====================
	assign sys_reset    = reset | reset_request | button_reset | rom_download | mode_pulse;

	// Mapper ignores menu and button resets
	assign mapper_reset = reset | rom_download | mode_pulse;

endmodule

// ==== rtl/trs_host_pkg.sv ====
// Host control package for the TRS-80 core
// Shared widths, download file indices, reset timing and audio scaling

package trs_host_pkg;

	// ====================
	// Download port
	// ====================
	localparam int data_w      = 8;
	localparam int host_addr_w = 16;
	localparam int index_w     = 8;

	// Top bit of the memory address selects the cassette region
	localparam int mem_addr_w = host_addr_w + 1;

	localparam logic [index_w-1:0] idx_system_rom = 8'd0;
	localparam logic [index_w-1:0] idx_cassette   = 8'd1;
	localparam logic [index_w-1:0] idx_alt_rom    = 8'd64;

	// 2 KB alternate boot ROM
	localparam int alt_rom_addr_w = 11;

	// Reset pulse after an alternate ROM mode switch
	localparam int mode_reset_cycles = 15;

	// ====================
	// Audio
	// ====================
	localparam int sys_audio_w     = 9;
	localparam int sys_audio_shift = 7;
	localparam int audio_w         = 16;

	typedef logic [data_w-1:0]      byte_t;
	typedef logic [host_addr_w-1:0] host_addr_t;
	typedef logic [mem_addr_w-1:0]  mem_addr_t;
	typedef logic [audio_w-1:0]     audio_t;

endpackage

// ==== rtl/trs_host_top.sv ====
// Host control top level for the TRS-80 core
// Download routing, boot ROM, reset generation, debug line and audio mix

`timescale 1ns/1ps

module trs_host_top import trs_host_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      reset_request,
	input  logic                      button_reset,
	input  logic                      alt_rom_mode,
	input  logic                      dl_active,
	input  logic                      dl_wr,
	input  logic [index_w-1:0]        dl_index,
	input  host_addr_t                dl_addr,
	input  byte_t                     dl_data,
	input  logic [alt_rom_addr_w-1:0] rom_read_addr,
	input  logic                      debug_request,
	input  host_addr_t                execute_addr,
	input  logic [sys_audio_w-1:0]    sys_audio,
	input  audio_t                    ext_audio,
	input  logic                      ext_audio_mute,
	output logic                      sys_reset,
	output logic                      mapper_reset,
	output logic                      rom_download,
	output logic                      cassette_download,
	output logic                      mem_wr,
	output mem_addr_t                 mem_addr,
	output byte_t                     mem_data,
	output byte_t                     rom_read_data,
	output logic                      debug_select_line,
	output audio_t                    audio_out
);

	logic                      rom_wr;
	logic [alt_rom_addr_w-1:0] rom_addr;
	byte_t                     rom_data;

	// ====================
	// Downloads
	// ====================

	// A ROM download holds sys_reset high, so the router
	// runs from the external reset to keep writing meanwhile
	download_router i_download_router (
		.clk_sys           (clk_sys),
		.sys_reset         (reset),
		.dl_active         (dl_active),
		.dl_wr             (dl_wr),
		.dl_index          (dl_index),
		.dl_addr           (dl_addr),
		.dl_data           (dl_data),
		.rom_download      (rom_download),
		.cassette_download (cassette_download),
		.mem_wr            (mem_wr),
		.mem_addr          (mem_addr),
		.mem_data          (mem_data),
		.rom_wr            (rom_wr),
		.rom_addr          (rom_addr),
		.rom_data          (rom_data)
	);

	alt_boot_rom i_alt_boot_rom (
		.clk_sys       (clk_sys),
		.rom_wr        (rom_wr),
		.rom_addr      (rom_addr),
		.rom_data      (rom_data),
		.rom_read_addr (rom_read_addr),
		.rom_read_data (rom_read_data)
	);

	// ====================
	// Resets
	// ====================
	reset_control i_reset_control (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.reset_request (reset_request),
		.button_reset  (button_reset),
		.rom_download  (rom_download),
		.alt_rom_mode  (alt_rom_mode),
		.sys_reset     (sys_reset),
		.mapper_reset  (mapper_reset)
	);

	// ====================
	// Debug and audio
	// ====================
	debug_line_select i_debug_line_select (
		.clk_sys           (clk_sys),
		.sys_reset         (sys_reset),
		.debug_request     (debug_request),
		.execute_addr      (execute_addr),
		.debug_select_line (debug_select_line)
	);

	audio_mixer i_audio_mixer (
		.clk_sys        (clk_sys),
		.sys_reset      (sys_reset),
		.sys_audio      (sys_audio),
		.ext_audio      (ext_audio),
		.ext_audio_mute (ext_audio_mute),
		.audio_out      (audio_out)
	);

endmodule

// ==== testbench/tb_trs_host_ref.svh ====
// Reference models for the host control testbench
// Download routing, boot ROM addressing, debug flag, audio mix and the LCG

// Download destinations
localparam int dest_none = 0;
localparam int dest_mem  = 1;
localparam int dest_rom  = 2;

// File index 0 and 1 go to shared memory, 64 to the boot ROM
function automatic int ref_route(input logic [index_w-1:0] index);
	if (index == 8'd0 || index == 8'd1)
		return dest_mem;
	if (index == 8'd64)
		return dest_rom;
	return dest_none;
endfunction

// Cassette data lands in the upper half of the memory map
function automatic mem_addr_t ref_mem_addr(input logic [index_w-1:0] index, input host_addr_t addr);
	return {index == 8'd1, addr};
endfunction

// Boot ROM holds 2048 bytes
function automatic int ref_rom_index(input host_addr_t addr);
	return int'(addr) % 2048;
endfunction

// New execute address sets the flag, else a falling request toggles it
function automatic logic ref_debug_next(input logic cur, input logic req_prev, input logic req,
		input host_addr_t addr_prev, input host_addr_t addr);
	if (addr != addr_prev)
		return 1'b1;
	if (req_prev && !req)
		return !cur;
	return cur;
endfunction

// Machine sound times 128 plus the signed sample in a 17-bit sum clamped to 16 bits
function automatic audio_t ref_mix(input logic [8:0] sys, input audio_t ext, input logic mute);
	int sum;
	sum = int'(sys) * 128;
	if (!mute)
		sum = sum + $signed(ext);
	// Signed 17-bit sum wraps above 65535
	if (sum > 65535)
		sum = sum - 131072;
	if (sum > 32767)
		sum = 32767;
	else if (sum < -32768)
		sum = -32768;
	return audio_t'(sum);
endfunction

function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1103515245 + 32'd12345;
endfunction

// ==== testbench/tb_trs_host.sv ====
// Testbench for the host control top level
// Checks download routing, boot ROM, resets, debug line and audio mix

`timescale 1ns/1ps

module tb_trs_host import trs_host_pkg::*; ();

	// Limit well above the length of all tests
	localparam int max_cycles = 4000;

	logic clk_sys, reset, reset_request, button_reset, alt_rom_mode;
	logic dl_active, dl_wr, debug_request, ext_audio_mute;
	logic [index_w-1:0] dl_index;
	host_addr_t dl_addr, execute_addr;
	byte_t dl_data, mem_data, rom_read_data;
	logic [alt_rom_addr_w-1:0] rom_read_addr;
	logic [sys_audio_w-1:0] sys_audio;
	audio_t ext_audio, audio_out;
	logic sys_reset, mapper_reset, rom_download, cassette_download, mem_wr, debug_select_line;
	mem_addr_t mem_addr;

	int          error_count = 0;
	int          test_count = 0;
	int          failed_tests = 0;
	int          cycle_count = 0;
	logic [31:0] lcg_state = 32'd62;
	mem_addr_t   exp_addr_q [$];
	byte_t       exp_data_q [$];
	byte_t       rom_ref [0:2047];
	logic [alt_rom_addr_w-1:0] rom_addrs [0:31];
	logic        audio_check = 1'b0;
	int          audio_valid = 0;
	audio_t      audio_hist [0:1];
	logic        exp_debug, prev_req;
	host_addr_t  prev_addr;

	`include "tb_trs_host_ref.svh"

	trs_host_top i_trs_host_top (.*);

	always #20 clk_sys = ~clk_sys;

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
		error_count++;
	endtask

	task automatic report_problem(input string text);
		$display("%s", text);
		error_count++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %0d %s: ok", test_count, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
		end
	endtask

	task automatic next_rand(output logic [15:0] value);
		lcg_state = lcg_next(lcg_state);
		value = lcg_state[31:16];
	endtask

	task automatic check_flags();
		if (rom_download !== (dl_active && dl_index == 8'd0))
			report_mismatch("rom_download", rom_download, dl_active && dl_index == 8'd0);
		if (cassette_download !== (dl_active && dl_index == 8'd1))
			report_mismatch("cassette_download", cassette_download, dl_active && dl_index == 8'd1);
	endtask

	// One host strobe, queued as an expected write when it qualifies
	task automatic host_write(input logic active, input logic [index_w-1:0] index,
			input host_addr_t addr, input byte_t data);
		@(posedge clk_sys);
		#2;
		dl_active = active;
		dl_wr     = 1'b1;
		dl_index  = index;
		dl_addr   = addr;
		dl_data   = data;
		if (active && ref_route(index) == dest_mem) begin
			exp_addr_q.push_back(ref_mem_addr(index, addr));
			exp_data_q.push_back(data);
		end
		if (active && ref_route(index) == dest_rom)
			rom_ref[ref_rom_index(addr)] = data;
		@(negedge clk_sys);
		check_flags();
	endtask

	task automatic host_idle(input int cycles);
		@(posedge clk_sys);
		#2;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		repeat (cycles) @(posedge clk_sys);
		@(negedge clk_sys);
		check_flags();
	endtask

	task automatic check_drained();
		if (exp_addr_q.size() != 0) begin
			report_problem($sformatf("%0d memory writes never appeared", exp_addr_q.size()));
			exp_addr_q.delete();
			exp_data_q.delete();
		end
	endtask

	task automatic rom_read_check(input logic [alt_rom_addr_w-1:0] addr);
		@(posedge clk_sys);
		#2;
		rom_read_addr = addr;
		@(posedge clk_sys);
		@(negedge clk_sys);
		if (rom_read_data !== rom_ref[addr])
			report_mismatch("rom_read_data", rom_read_data, rom_ref[addr]);
	endtask

	task automatic mode_switch_check(input logic mode);
		int high_count;
		int i;
		high_count = 0;
		@(posedge clk_sys);
		#2;
		alt_rom_mode = mode;
		@(negedge clk_sys);
		if (sys_reset !== 1'b0)
			report_problem("sys_reset rose before the mode change was sampled");
		for (i = 0; i < 30; i++) begin
			@(negedge clk_sys);
			if (mapper_reset !== sys_reset)
				report_mismatch("mapper_reset", mapper_reset, sys_reset);
			if (sys_reset === 1'b1) begin
				if (i != high_count)
					report_problem("mode reset pulse started late or had a gap");
				high_count++;
			end
		end
		if (high_count != 15)
			report_problem($sformatf("mode reset pulse lasted %0d cycles, not 15", high_count));
	endtask

	task automatic reset_source_check(input logic req, input logic button, input logic rom_dl);
		@(posedge clk_sys);
		#2;
		reset_request = req;
		button_reset  = button;
		dl_active     = rom_dl;
		dl_index      = 8'd0;
		@(negedge clk_sys);
		if (sys_reset !== (req | button | rom_dl))
			report_mismatch("sys_reset", sys_reset, req | button | rom_dl);
		if (mapper_reset !== rom_dl)
			report_mismatch("mapper_reset", mapper_reset, rom_dl);
	endtask

	task automatic debug_step(input logic req, input host_addr_t addr);
		@(posedge clk_sys);
		#2;
		debug_request = req;
		execute_addr  = addr;
		exp_debug = ref_debug_next(exp_debug, prev_req, req, prev_addr, addr);
		prev_req  = req;
		prev_addr = addr;
		@(posedge clk_sys);
		@(negedge clk_sys);
		if (debug_select_line !== exp_debug)
			report_mismatch("debug_select_line", debug_select_line, exp_debug);
	endtask

	task automatic audio_vector(input logic [8:0] sys, input audio_t ext, input logic mute);
		@(posedge clk_sys);
		#2;
		sys_audio      = sys;
		ext_audio      = ext;
		ext_audio_mute = mute;
		audio_check    = 1'b1;
	endtask

	// ====================
	// Compare process
	// ====================
	always @(negedge clk_sys) begin
		if (mem_wr === 1'b1) begin
			if (exp_addr_q.size() == 0) begin
				report_problem("mem_wr pulsed without a qualifying download write");
			end else begin
				if (mem_addr !== exp_addr_q[0])
					report_mismatch("mem_addr", mem_addr, exp_addr_q[0]);
				if (mem_data !== exp_data_q[0])
					report_mismatch("mem_data", mem_data, exp_data_q[0]);
				void'(exp_addr_q.pop_front());
				void'(exp_data_q.pop_front());
			end
		end
		// Output now reflects the inputs seen two falling edges ago
		if (audio_check) begin
			if (audio_valid >= 2 && audio_out !== audio_hist[1])
				report_mismatch("audio_out", audio_out, audio_hist[1]);
			audio_hist[1] = audio_hist[0];
			audio_hist[0] = ref_mix(sys_audio, ext_audio, ext_audio_mute);
			if (audio_valid < 2)
				audio_valid++;
		end else begin
			audio_valid = 0;
		end
	end

	// Cycle counter that stops a stuck run
	initial begin
		while (cycle_count < max_cycles) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("timeout: run stopped after %0d cycles", cycle_count);
		$display("Done: errors found");
		$finish;
	end

	// ====================
	// Stimulus
	// ====================
	initial begin
		int errors_before;
		int i;
		logic [15:0] r1, r2, r3;
		clk_sys = 1'b0;
		reset = 1'b1;
		reset_request = 1'b0;
		button_reset = 1'b0;
		alt_rom_mode = 1'b0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_index = '0;
		dl_addr = '0;
		dl_data = '0;
		rom_read_addr = '0;
		debug_request = 1'b0;
		execute_addr = '0;
		sys_audio = '0;
		ext_audio = '0;
		ext_audio_mute = 1'b0;
		repeat (16) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		repeat (2) @(posedge clk_sys);

		errors_before = error_count;
		for (i = 0; i < 40; i++) begin
			next_rand(r1);
			next_rand(r2);
			if (r2[15:13] == 3'd0)
				host_idle(1);
			host_write(1'b1, (i < 20) ? 8'd0 : 8'd1, r1, r2[7:0]);
		end
		host_idle(3);
		check_drained();
		finish_test("system ROM and cassette download", errors_before);

		errors_before = error_count;
		for (i = 0; i < 32; i++) begin
			next_rand(r1);
			next_rand(r2);
			rom_addrs[i] = ref_rom_index(r1);
			host_write(1'b1, 8'd64, r1, r2[7:0]);
		end
		host_idle(3);
		for (i = 0; i < 32; i++)
			rom_read_check(rom_addrs[i]);
		check_drained();
		finish_test("alternate ROM download and readback", errors_before);

		errors_before = error_count;
		next_rand(r1);
		host_write(1'b1, 8'd2, r1, r1[7:0]);
		host_write(1'b1, 8'd7, r1 + 16'd1, r1[15:8]);
		host_write(1'b1, 8'd65, host_addr_t'(rom_addrs[0]), ~rom_ref[rom_addrs[0]]);
		host_write(1'b0, 8'd0, r1, r1[7:0]);
		host_write(1'b0, 8'd1, r1, r1[15:8]);
		host_write(1'b0, 8'd64, host_addr_t'(rom_addrs[1]), ~rom_ref[rom_addrs[1]]);
		host_idle(3);
		rom_read_check(rom_addrs[0]);
		rom_read_check(rom_addrs[1]);
		check_drained();
		finish_test("ignored writes", errors_before);

		errors_before = error_count;
		mode_switch_check(1'b1);
		mode_switch_check(1'b0);
		reset_source_check(1'b1, 1'b0, 1'b0);
		reset_source_check(1'b0, 1'b0, 1'b0);
		reset_source_check(1'b0, 1'b1, 1'b0);
		reset_source_check(1'b0, 1'b0, 1'b0);
		reset_source_check(1'b0, 1'b0, 1'b1);
		reset_source_check(1'b0, 1'b0, 1'b0);
		finish_test("reset sources", errors_before);

		errors_before = error_count;
		exp_debug = 1'b0;
		prev_req  = debug_request;
		prev_addr = execute_addr;
		@(negedge clk_sys);
		if (debug_select_line !== 1'b0)
			report_mismatch("debug_select_line", debug_select_line, 1'b0);
		debug_step(1'b1, 16'h0000);
		debug_step(1'b0, 16'h0000);
		debug_step(1'b1, 16'h0000);
		debug_step(1'b0, 16'h0000);
		debug_step(1'b0, 16'h1234);
		debug_step(1'b1, 16'h1234);
		// Falling request and new address together
		debug_step(1'b0, 16'h4000);
		debug_step(1'b1, 16'h4000);
		debug_step(1'b0, 16'h4000);
		debug_step(1'b0, 16'h4001);
		finish_test("debug line select", errors_before);

		errors_before = error_count;
		for (i = 0; i < 200; i++) begin
			next_rand(r1);
			next_rand(r2);
			next_rand(r3);
			audio_vector(r1[8:0], r2, r3[15:13] == 3'd0);
		end
		audio_vector(9'h1FF, 16'h7FFF, 1'b0);
		audio_vector(9'h1FF, 16'h8000, 1'b0);
		audio_vector(9'h000, 16'h8000, 1'b0);
		audio_vector(9'h1FF, 16'h7FFF, 1'b1);
		audio_vector(9'h000, 16'h8000, 1'b1);
		repeat (3) @(posedge clk_sys);
		#2;
		audio_check = 1'b0;
		finish_test("audio mixer", errors_before);

		check_drained();
		$display("tests run %0d, tests failed %0d, errors %0d", test_count, failed_tests,
			error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
